/* design/ocl_pkg.sv */
// --------------------------------------------------
// Shared widths, register map and opcode encoding
// for the OCL register window
// --------------------------------------------------
`default_nettype none

package ocl_pkg;

  // Bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;
  localparam int LED_W  = 16;
  localparam int ID_W   = 28;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [1:0]        resp_t;
  typedef logic [LED_W-1:0]  led_t;
  typedef logic [ID_W-1:0]   cmd_id_t;

  // Command opcode, top three bits of the command word
  typedef enum logic [2:0] {
    DEL = 3'd0,
    ADD = 3'd1,
    SET = 3'd2,
    RDC = 3'd3,
    MSC = 3'd4
  } opcode_t;

  // --------------------------------------------------
  // Register map
  // --------------------------------------------------
  localparam addr_t HELLO_ADDR_DEF = 32'h0000_0500;
  localparam addr_t VLED_ADDR_DEF  = 32'h0000_0504;

  // Returned for any address outside the map
  localparam data_t UNMAPPED_VALUE = 32'hDEAD_BEEF;

  // Only response code ever returned
  localparam resp_t RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

/* design/reg_bus_if.sv */
// --------------------------------------------------
// Register access bus, AXI-Lite front end to regs
// --------------------------------------------------
`default_nettype none

interface reg_bus_if (
  input logic clk_main_a0
);
  import ocl_pkg::*;

  // Write side, one-cycle pulse per accepted data beat
  logic  wr_strobe;
  addr_t wr_addr;
  data_t wr_data;

  // Read side, data is combinational on rd_addr
  addr_t rd_addr;
  data_t rd_data;

  // AXI-Lite front end
  modport slave (
    input  clk_main_a0,
    output wr_strobe, wr_addr, wr_data, rd_addr,
    input  rd_data
  );

  // Register block
  modport regs (
    input  clk_main_a0,
    input  wr_strobe, wr_addr, wr_data, rd_addr,
    output rd_data
  );

endinterface

`default_nettype wire

/* design/axil_slave.sv */
// --------------------------------------------------
// AXI4-Lite single-beat slave front end
// Write address/data/response and read channel state
// --------------------------------------------------
`default_nettype none

module axil_slave (
  input  wire logic           clk_main_a0,
  input  wire logic           rst_main_n_sync,
  // Write address
  input  wire logic           awvalid,
  input  wire ocl_pkg::addr_t awaddr,
  output logic                awready,
  // Write data
  input  wire logic           wvalid,
  input  wire ocl_pkg::data_t wdata,
  input  wire ocl_pkg::strb_t wstrb,
  output logic                wready,
  // Write response
  output logic                bvalid,
  output ocl_pkg::resp_t      bresp,
  input  wire logic           bready,
  // Read address
  input  wire logic           arvalid,
  input  wire ocl_pkg::addr_t araddr,
  output logic                arready,
  // Read data
  output logic                rvalid,
  output ocl_pkg::data_t      rdata,
  output ocl_pkg::resp_t      rresp,
  input  wire logic           rready,
  // Register side
  reg_bus_if.slave            bus
);
  import ocl_pkg::*;

  // Write in flight, from address accept to response handshake
  logic  wr_active;
  addr_t wr_addr_q;

  // Read address accepted last cycle
  logic  ar_pend;
  addr_t rd_addr_q;

  // --------------------------------------------------
  // Write channel
  // --------------------------------------------------

  // Only one write at a time
  assign awready = ~wr_active;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_active <= 1'b0;
    end else if (wr_active && bvalid && bready) begin
      // Response taken, window free again
      wr_active <= 1'b0;
    end else if (!wr_active && awvalid) begin
      wr_active <= 1'b1;
    end
  end

  // Address held for the whole write
  always_ff @(posedge clk_main_a0) begin
    if (awvalid && awready) begin
      wr_addr_q <= awaddr;
    end
  end

  // Data beat taken as soon as the address is known
  assign wready = wr_active && wvalid;

  // Response raised after the data beat, held until bready
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      bvalid <= 1'b0;
    end else if (bvalid && bready) begin
      bvalid <= 1'b0;
    end else if (!bvalid && wready) begin
      bvalid <= 1'b1;
    end
  end

  assign bresp = RESP_OKAY;

  // Register write strobe on the data beat
  // Strobes are ignored, every write is a full word (wstrb not decoded)
  assign bus.wr_strobe = wready;
  assign bus.wr_addr   = wr_addr_q;
  assign bus.wr_data   = wdata;

  // --------------------------------------------------
  // Read channel
  // --------------------------------------------------

  // Blocked while a lookup or a response is outstanding
  assign arready = !ar_pend && !rvalid;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      ar_pend <= 1'b0;
    end else begin
      ar_pend <= arvalid && arready;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (arvalid && arready) begin
      rd_addr_q <= araddr;
    end
  end

  // Regs decode the captured address combinationally
  assign bus.rd_addr = rd_addr_q;

  // Response loaded one cycle after the lookup, cleared on rready
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rvalid <= 1'b0;
      rdata  <= '0;
      rresp  <= RESP_OKAY;
    end else if (rvalid && rready) begin
      rvalid <= 1'b0;
      rdata  <= '0;
      rresp  <= RESP_OKAY;
    end else if (ar_pend) begin
      rvalid <= 1'b1;
      rdata  <= bus.rd_data;
      rresp  <= RESP_OKAY;
    end
  end

endmodule

`default_nettype wire

/* design/ocl_regs.sv */
// --------------------------------------------------
// Command register with opcode decode
// Byte-swapped readback and read data select
// --------------------------------------------------
`default_nettype none

module ocl_regs #(
  parameter ocl_pkg::addr_t HELLO_ADDR = ocl_pkg::HELLO_ADDR_DEF,
  parameter ocl_pkg::addr_t VLED_ADDR  = ocl_pkg::VLED_ADDR_DEF
) (
  input  wire logic          clk_main_a0,
  input  wire logic          rst_main_n_sync,
  // Registered LED shadow, for readback
  input  wire ocl_pkg::led_t vled_value,
  // Low command bits to the LED shadow
  output ocl_pkg::led_t      cmd_low,
  reg_bus_if.regs            bus
);
  import ocl_pkg::*;

  // Command register fields
  opcode_t cmd_op;
  logic    cmd_mode;
  cmd_id_t cmd_id;

  // Packed command word and its byte-reversed form
  data_t cmd_word;
  data_t cmd_swapped;

  // Field 4..7 all fold into MSC
  function automatic opcode_t decode_op(input logic [2:0] field);
    opcode_t op;
    case (field)
      3'd0:    op = DEL;
      3'd1:    op = ADD;
      3'd2:    op = SET;
      3'd3:    op = RDC;
      default: op = MSC;
    endcase
    return op;
  endfunction

  // --------------------------------------------------
  // Command register
  // --------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      cmd_op   <= DEL;
      cmd_mode <= 1'b0;
      cmd_id   <= '0;
    end else if (bus.wr_strobe && (bus.wr_addr == HELLO_ADDR)) begin
      // Opcode in 31..29, mode in 28, id below
      cmd_op   <= decode_op(bus.wr_data[31:29]);
      cmd_mode <= bus.wr_data[28];
      cmd_id   <= bus.wr_data[27:0];
    end
  end

  assign cmd_word = {cmd_op, cmd_mode, cmd_id};

  // LSB byte comes back first
  assign cmd_swapped = {cmd_word[7:0],   cmd_word[15:8],
                        cmd_word[23:16], cmd_word[31:24]};

  // LED shadow follows the low half
  assign cmd_low = cmd_word[LED_W-1:0];

  // --------------------------------------------------
  // Read data select
  // --------------------------------------------------
  always_comb begin
    if (bus.rd_addr == HELLO_ADDR) begin
      bus.rd_data = cmd_swapped;
    end else if (bus.rd_addr == VLED_ADDR) begin
      // LEDs zero-extended to the bus width
      bus.rd_data = {{(DATA_W-LED_W){1'b0}}, vled_value};
    end else begin
      bus.rd_data = UNMAPPED_VALUE;
    end
  end

endmodule

`default_nettype wire

/* design/vled_shadow.sv */
// --------------------------------------------------
// Virtual LED shadow, DIP synchronizer and
// masked LED output flop
// --------------------------------------------------
`default_nettype none

module vled_shadow #(
  parameter int SYNC_STAGES = 2
) (
  input  wire logic          clk_main_a0,
  input  wire logic          rst_main_n_sync,
  // Low command bits
  input  wire ocl_pkg::led_t cmd_low,
  // Virtual DIP switches, asynchronous to this clock
  input  wire ocl_pkg::led_t vdip,
  // Shadow value for readback
  output ocl_pkg::led_t      vled_value,
  // Masked LEDs to the shell
  output ocl_pkg::led_t      status_vled
);
  import ocl_pkg::*;

  led_t vled_q;
  led_t vdip_sync [SYNC_STAGES];

  // LED shadow, one cycle behind the command register
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vled_q <= '0;
    end else begin
      vled_q <= cmd_low;
    end
  end

  assign vled_value = vled_q;

  // DIP flop chain
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        vdip_sync[i] <= '0;
      end
    end else begin
      vdip_sync[0] <= vdip;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        vdip_sync[i] <= vdip_sync[i-1];
      end
    end
  end

  // Switch off gates the LED, result registered
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      status_vled <= '0;
    end else begin
      status_vled <= vled_q & vdip_sync[SYNC_STAGES-1];
    end
  end

endmodule

`default_nettype wire

/* design/cl_hello_top.sv */
// --------------------------------------------------
// Top level of the OCL register window
// AXI-Lite slave, command regs and LED shadow
// --------------------------------------------------
`default_nettype none

module cl_hello_top #(
  parameter ocl_pkg::addr_t HELLO_ADDR  = ocl_pkg::HELLO_ADDR_DEF,
  parameter ocl_pkg::addr_t VLED_ADDR   = ocl_pkg::VLED_ADDR_DEF,
  parameter int             SYNC_STAGES = 2
) (
  input  wire logic           clk_main_a0,
  input  wire logic           rst_main_n_sync,
  // OCL write address
  input  wire logic           sh_ocl_awvalid,
  input  wire ocl_pkg::addr_t sh_ocl_awaddr,
  output logic                ocl_sh_awready,
  // OCL write data
  input  wire logic           sh_ocl_wvalid,
  input  wire ocl_pkg::data_t sh_ocl_wdata,
  input  wire ocl_pkg::strb_t sh_ocl_wstrb,
  output logic                ocl_sh_wready,
  // OCL write response
  output logic                ocl_sh_bvalid,
  output ocl_pkg::resp_t      ocl_sh_bresp,
  input  wire logic           sh_ocl_bready,
  // OCL read address
  input  wire logic           sh_ocl_arvalid,
  input  wire ocl_pkg::addr_t sh_ocl_araddr,
  output logic                ocl_sh_arready,
  // OCL read data
  output logic                ocl_sh_rvalid,
  output ocl_pkg::data_t      ocl_sh_rdata,
  output ocl_pkg::resp_t      ocl_sh_rresp,
  input  wire logic           sh_ocl_rready,
  // Virtual DIP in, virtual LED out
  input  wire ocl_pkg::led_t  sh_cl_status_vdip,
  output ocl_pkg::led_t       cl_sh_status_vled
);
  import ocl_pkg::*;

  // Command low half and LED shadow between regs and LED block
  led_t cmd_low;
  led_t vled_value;

  reg_bus_if bus (
    .clk_main_a0 (clk_main_a0)
  );

  axil_slave u_axil_slave (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (sh_ocl_awvalid),
    .awaddr          (sh_ocl_awaddr),
    .awready         (ocl_sh_awready),
    .wvalid          (sh_ocl_wvalid),
    .wdata           (sh_ocl_wdata),
    .wstrb           (sh_ocl_wstrb),
    .wready          (ocl_sh_wready),
    .bvalid          (ocl_sh_bvalid),
    .bresp           (ocl_sh_bresp),
    .bready          (sh_ocl_bready),
    .arvalid         (sh_ocl_arvalid),
    .araddr          (sh_ocl_araddr),
    .arready         (ocl_sh_arready),
    .rvalid          (ocl_sh_rvalid),
    .rdata           (ocl_sh_rdata),
    .rresp           (ocl_sh_rresp),
    .rready          (sh_ocl_rready),
    .bus             (bus.slave)
  );

  ocl_regs #(
    .HELLO_ADDR (HELLO_ADDR),
    .VLED_ADDR  (VLED_ADDR)
  ) u_ocl_regs (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .vled_value      (vled_value),
    .cmd_low         (cmd_low),
    .bus             (bus.regs)
  );

  vled_shadow #(
    .SYNC_STAGES (SYNC_STAGES)
  ) u_vled_shadow (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .cmd_low         (cmd_low),
    .vdip            (sh_cl_status_vdip),
    .vled_value      (vled_value),
    .status_vled     (cl_sh_status_vled)
  );

endmodule

`default_nettype wire

/* verification/axil_slave_chk.sv */
// --------------------------------------------------
// AXI-Lite response handshake and reset assertions
// --------------------------------------------------
`default_nettype none

module axil_slave_chk (
  input wire logic           clk_main_a0,
  input wire logic           rst_main_n_sync,
  input wire logic           bvalid,
  input wire logic           bready,
  input wire ocl_pkg::resp_t bresp,
  input wire logic           rvalid,
  input wire logic           rready,
  input wire ocl_pkg::data_t rdata,
  input wire ocl_pkg::resp_t rresp
);
  timeunit 1ns;
  timeprecision 100ps;
  import ocl_pkg::*;

  // Failures seen so far, read by the testbench at the end
  int fail_cnt = 0;

  // Write response held until taken
  bvalid_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    bvalid && !bready |=> bvalid)
    else begin
      $error("bvalid dropped before bready");
      fail_cnt++;
    end

  // Read response and its data held until taken
  rvalid_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else begin
      $error("rvalid or rdata changed before rready");
      fail_cnt++;
    end

  resp_okay: assert property (@(posedge clk_main_a0)
    bresp == RESP_OKAY && rresp == RESP_OKAY)
    else begin
      $error("non-OKAY response code");
      fail_cnt++;
    end

  // No response straight out of reset
  reset_idle: assert property (@(posedge clk_main_a0)
    !rst_main_n_sync |=> !bvalid && !rvalid)
    else begin
      $error("response valid after reset");
      fail_cnt++;
    end

endmodule

bind axil_slave axil_slave_chk chk0 (
  .clk_main_a0     (clk_main_a0),
  .rst_main_n_sync (rst_main_n_sync),
  .bvalid          (bvalid),
  .bready          (bready),
  .bresp           (bresp),
  .rvalid          (rvalid),
  .rready          (rready),
  .rdata           (rdata),
  .rresp           (rresp)
);

`default_nettype wire

/* verification/tb_top.sv */
// --------------------------------------------------
// Testbench for the OCL register window
// Random AXI-Lite traffic checked against a model
// --------------------------------------------------
`default_nettype none

module tb_top;
  timeunit 1ns;
  timeprecision 100ps;
  import ocl_pkg::*;

  localparam int    SYNC_STAGES    = 2;
  localparam int    NUM_TXN        = 300;
  localparam int    MAX_DELAY      = 6;
  // Roughly 20 cycles per transaction plus margin
  localparam int    TIMEOUT_CYCLES = NUM_TXN * 20 + 2000;
  localparam addr_t HELLO_ADDR     = HELLO_ADDR_DEF;
  localparam addr_t VLED_ADDR      = VLED_ADDR_DEF;

  logic  clk_main_a0;
  logic  rst_main_n_sync;
  logic  sh_ocl_awvalid, sh_ocl_wvalid, sh_ocl_bready, sh_ocl_arvalid, sh_ocl_rready;
  addr_t sh_ocl_awaddr, sh_ocl_araddr;
  data_t sh_ocl_wdata;
  strb_t sh_ocl_wstrb;
  led_t  sh_cl_status_vdip;
  logic  ocl_sh_awready, ocl_sh_wready, ocl_sh_bvalid, ocl_sh_arready, ocl_sh_rvalid;
  resp_t ocl_sh_bresp, ocl_sh_rresp;
  data_t ocl_sh_rdata;
  led_t  cl_sh_status_vled;

  int     errors = 0;
  int     checks = 0;
  int     cycle_cnt = 0;
  integer seed = 32'h69d2_4d2c;
  // Model command word with the opcode already folded
  data_t  cmd_model = '0;
  led_t   dip_model;

  cl_hello_top #(.HELLO_ADDR(HELLO_ADDR), .VLED_ADDR(VLED_ADDR), .SYNC_STAGES(SYNC_STAGES))
    dut0 (.*);

  initial clk_main_a0 = 1'b0;
  always #2 clk_main_a0 = ~clk_main_a0;

  // Run limit
  always @(posedge clk_main_a0) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Errors found");
      $finish;
    end
  end

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % n);
  endfunction

  // Opcode fields 4..7 fold to MSC
  function automatic data_t fold_cmd(input data_t w);
    logic [2:0] op;
    op = (w[31:29] > 3'd3) ? 3'd4 : w[31:29];
    return {op, w[28:0]};
  endfunction

  // Byte order reversed
  function automatic data_t swap_bytes(input data_t w);
    data_t s;
    for (int b = 0; b < 4; b++) begin
      s[8*b +: 8] = w[8*(3-b) +: 8];
    end
    return s;
  endfunction

  function automatic addr_t random_unmapped();
    addr_t a;
    a = $random(seed);
    a[1:0] = 2'b00;
    if (a == HELLO_ADDR || a == VLED_ADDR) a = 32'h0000_0600;
    return a;
  endfunction

  task automatic compare(input string what, input data_t got, input data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic axi_write(input addr_t addr, input data_t data);
    // Address phase
    @(posedge clk_main_a0);
    sh_ocl_awvalid <= 1'b1;
    sh_ocl_awaddr  <= addr;
    @(negedge clk_main_a0);
    while (!ocl_sh_awready) @(negedge clk_main_a0);
    @(posedge clk_main_a0);
    sh_ocl_awvalid <= 1'b0;
    // Data phase after a random gap
    repeat (rand_below(MAX_DELAY + 1)) @(posedge clk_main_a0);
    sh_ocl_wvalid <= 1'b1;
    sh_ocl_wdata  <= data;
    sh_ocl_wstrb  <= 4'hf;
    @(negedge clk_main_a0);
    while (!ocl_sh_wready) @(negedge clk_main_a0);
    @(posedge clk_main_a0);
    sh_ocl_wvalid <= 1'b0;
    // Response due one cycle after the data beat and held under back-pressure
    @(negedge clk_main_a0);
    compare("bvalid", {31'h0, ocl_sh_bvalid}, 32'd1);
    compare("bresp", {30'h0, ocl_sh_bresp}, 32'd0);
    repeat (rand_below(MAX_DELAY + 1)) begin
      @(negedge clk_main_a0);
      compare("bvalid held", {31'h0, ocl_sh_bvalid}, 32'd1);
    end
    @(posedge clk_main_a0);
    sh_ocl_bready <= 1'b1;
    @(posedge clk_main_a0);
    sh_ocl_bready <= 1'b0;
    // No second response
    @(negedge clk_main_a0);
    compare("bvalid after handshake", {31'h0, ocl_sh_bvalid}, 32'd0);
  endtask

  task automatic axi_read(input addr_t addr, input data_t exp);
    @(posedge clk_main_a0);
    sh_ocl_arvalid <= 1'b1;
    sh_ocl_araddr  <= addr;
    @(negedge clk_main_a0);
    while (!ocl_sh_arready) @(negedge clk_main_a0);
    @(posedge clk_main_a0);
    sh_ocl_arvalid <= 1'b0;
    // rvalid exactly two cycles after acceptance
    @(negedge clk_main_a0);
    compare("rvalid early", {31'h0, ocl_sh_rvalid}, 32'd0);
    @(negedge clk_main_a0);
    compare("rvalid", {31'h0, ocl_sh_rvalid}, 32'd1);
    compare("rdata", ocl_sh_rdata, exp);
    compare("rresp", {30'h0, ocl_sh_rresp}, 32'd0);
    repeat (rand_below(MAX_DELAY + 1)) begin
      @(negedge clk_main_a0);
      compare("rvalid held", {31'h0, ocl_sh_rvalid}, 32'd1);
      compare("rdata held", ocl_sh_rdata, exp);
    end
    @(posedge clk_main_a0);
    sh_ocl_rready <= 1'b1;
    @(posedge clk_main_a0);
    sh_ocl_rready <= 1'b0;
    @(negedge clk_main_a0);
    compare("rvalid after handshake", {31'h0, ocl_sh_rvalid}, 32'd0);
  endtask

  // New DIP value and the masked LED output past the synchronizer and output flop
  task automatic check_mask(input led_t dip);
    @(posedge clk_main_a0);
    sh_cl_status_vdip <= dip;
    dip_model = dip;
    repeat (SYNC_STAGES + 3) @(posedge clk_main_a0);
    @(negedge clk_main_a0);
    compare("status_vled", {16'h0, cl_sh_status_vled}, {16'h0, cmd_model[15:0] & dip_model});
  endtask

  initial begin
    data_t rnd;
    int    kind;
    int    assert_fails;
    rst_main_n_sync   = 1'b0;
    sh_ocl_awvalid    = 1'b0;
    sh_ocl_awaddr     = '0;
    sh_ocl_wvalid     = 1'b0;
    sh_ocl_wdata      = '0;
    sh_ocl_wstrb      = '0;
    sh_ocl_bready     = 1'b0;
    sh_ocl_arvalid    = 1'b0;
    sh_ocl_araddr     = '0;
    sh_ocl_rready     = 1'b0;
    rnd               = $random(seed);
    dip_model         = rnd[15:0];
    sh_cl_status_vdip = dip_model;
    repeat (8) @(posedge clk_main_a0);
    rst_main_n_sync <= 1'b1;
    // ----------------------------------------------
    // Reset state
    // ----------------------------------------------
    @(negedge clk_main_a0);
    compare("awready", {31'h0, ocl_sh_awready}, 32'd1);
    compare("arready", {31'h0, ocl_sh_arready}, 32'd1);
    compare("wready", {31'h0, ocl_sh_wready}, 32'd0);
    compare("bvalid", {31'h0, ocl_sh_bvalid}, 32'd0);
    compare("rvalid", {31'h0, ocl_sh_rvalid}, 32'd0);
    compare("status_vled", {16'h0, cl_sh_status_vled}, 32'd0);
    // ----------------------------------------------
    // Random traffic
    // ----------------------------------------------
    for (int n = 0; n < NUM_TXN; n++) begin
      kind = rand_below(6);
      rnd  = $random(seed);
      case (kind)
        0, 1: begin
          axi_write(HELLO_ADDR, rnd);
          cmd_model = fold_cmd(rnd);
          axi_read(HELLO_ADDR, swap_bytes(cmd_model));
        end
        // Writes outside the command register leave it alone
        2: axi_write(rnd[0] ? VLED_ADDR : random_unmapped(), rnd);
        3: axi_read(VLED_ADDR, {16'h0, cmd_model[15:0]});
        4: axi_read(random_unmapped(), UNMAPPED_VALUE);
        default: check_mask(rnd[15:0]);
      endcase
    end
    assert_fails = dut0.u_axil_slave.chk0.fail_cnt;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
design/ocl_pkg.sv
design/reg_bus_if.sv
design/axil_slave.sv
design/ocl_regs.sv
design/vled_shadow.sv
design/cl_hello_top.sv
verification/axil_slave_chk.sv
verification/tb_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the OCL register window testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_top \
  -Mdir obj_dir \
  -f sources.f

status=0
./obj_dir/Vtb_top +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -eq 0 ] && grep -qx "No errors" sim.log; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed"
exit 1
